// File: frontend_defines.svh
`ifndef FRONTEND_DEFINES_SVH
`define FRONTEND_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Front end widths
////////////////////////////////////////////////////////////////////////////

// Instruction word, RV32 encoding
`define FE_INST_W 32

// PC and branch target width
`define FE_ADDR_W 32

////////////////////////////////////////////////////////////////////////////
// Instruction buffer geometry
////////////////////////////////////////////////////////////////////////////

// Entries in the circular queue
`define FE_BUF_DEPTH 32

// Head/tail index bits, log2 of the depth
`define FE_PTR_W 5

`endif

// File: fe_types_pkg.sv
`include "frontend_defines.svh"

////////////////////////////////////////////////////////////////////////////
// Data carried through the front end
////////////////////////////////////////////////////////////////////////////

package fe_types_pkg;

    // Raw fetched instruction
    typedef logic [`FE_INST_W-1:0] inst_t;

    // Instruction address, also used for the static branch target
    typedef logic [`FE_ADDR_W-1:0] addr_t;

endpackage

// File: fe_ctrl_pkg.sv
`include "frontend_defines.svh"

////////////////////////////////////////////////////////////////////////////
// Buffer bookkeeping
////////////////////////////////////////////////////////////////////////////

package fe_ctrl_pkg;

    // Head or tail index, wraps at the buffer depth
    typedef logic [`FE_PTR_W-1:0] ptr_t;

    // Occupancy, one extra bit so a full buffer is representable
    typedef logic [`FE_PTR_W:0] count_t;

    // Entries handed to decode in one cycle, 0 to 2
    typedef logic [1:0] issue_cnt_t;

endpackage

// File: branch_predecode.sv
module branch_predecode (
    input  fe_types_pkg::addr_t pc_i,
    input  fe_types_pkg::inst_t inst_i,
    output logic                is_branch_o,
    output fe_types_pkg::addr_t target_o
);

    import fe_types_pkg::*;

    // RV32 major opcodes of interest
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    logic [6:0]         opcode;
    logic signed [12:0] b_off;
    logic signed [20:0] j_off;
    addr_t              offset;

    assign opcode = inst_i[6:0];

    // B-type immediate, bit 0 always zero
    assign b_off = {inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

    // J-type immediate, bit 0 always zero
    assign j_off = {inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    ////////////////////////////////////////////////////////////////////////////
    // Classification and offset select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (opcode)
            opc_branch: begin
                is_branch_o = 1'b1;
                offset      = addr_t'(b_off);
            end
            opc_jal: begin
                is_branch_o = 1'b1;
                offset      = addr_t'(j_off);
            end
            default: begin
                // Fall through to the next sequential PC
                is_branch_o = 1'b0;
                offset      = addr_t'(4);
            end
        endcase
    end

    // Static target, taken path for branches
    assign target_o = pc_i + offset;

endmodule

// File: issue_select.sv
module issue_select (
    input  fe_ctrl_pkg::count_t     count_i,
    input  logic                    head_is_branch_i,
    input  logic                    flush_i,
    input  logic                    pause_i,
    input  logic                    stall_i,
    output fe_ctrl_pkg::issue_cnt_t issue_cnt_o
);

    import fe_ctrl_pkg::*;

    logic hold_issue;

    // Any control active means nothing leaves the buffer
    assign hold_issue = flush_i || pause_i || stall_i;

    ////////////////////////////////////////////////////////////////////////////
    // Issue group sizing
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (hold_issue || (count_i == count_t'(0))) begin
            issue_cnt_o = issue_cnt_t'(0);
        end else if ((count_i == count_t'(1)) || head_is_branch_i) begin
            // Group closes after a branch, so it goes out alone in slot 0
            issue_cnt_o = issue_cnt_t'(1);
        end else begin
            issue_cnt_o = issue_cnt_t'(2);
        end
    end

endmodule

// File: inst_buffer.sv
`include "frontend_defines.svh"

module inst_buffer (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    input  logic                    pause_i,
    input  logic                    push_i,
    input  fe_types_pkg::inst_t     push_inst_i,
    input  fe_types_pkg::addr_t     push_pc_i,
    input  logic                    push_is_branch_i,
    input  fe_types_pkg::addr_t     push_target_i,
    input  fe_ctrl_pkg::issue_cnt_t issue_cnt_i,
    output fe_ctrl_pkg::count_t     count_o,
    output logic                    head_is_branch_o,
    output logic                    buf_full_o,
    output logic                    slot0_valid_o,
    output fe_types_pkg::inst_t     slot0_inst_o,
    output fe_types_pkg::addr_t     slot0_pc_o,
    output logic                    slot0_is_branch_o,
    output fe_types_pkg::addr_t     slot0_target_o,
    output logic                    slot1_valid_o,
    output fe_types_pkg::inst_t     slot1_inst_o,
    output fe_types_pkg::addr_t     slot1_pc_o,
    output logic                    slot1_is_branch_o,
    output fe_types_pkg::addr_t     slot1_target_o
);

    import fe_types_pkg::*;
    import fe_ctrl_pkg::*;

    // Parallel entry storage
    inst_t inst_mem [`FE_BUF_DEPTH];
    addr_t pc_mem   [`FE_BUF_DEPTH];
    logic  br_mem   [`FE_BUF_DEPTH];
    addr_t tgt_mem  [`FE_BUF_DEPTH];

    ptr_t   head_q;
    ptr_t   tail_q;
    ptr_t   head_p1;
    count_t count_q;
    logic   do_push;
    logic   take0;
    logic   take1;
    logic   hold_slots;

    // Instruction arriving with a flush is dropped
    assign do_push = push_i && !flush_i;

    // Second issue entry, wraps with the pointer width
    assign head_p1 = head_q + ptr_t'(1);

    assign take0 = (issue_cnt_i != issue_cnt_t'(0));
    assign take1 = (issue_cnt_i == issue_cnt_t'(2));

    // Flush overrides pause
    assign hold_slots = pause_i && !flush_i;

    ////////////////////////////////////////////////////////////////////////////
    // Entry write at tail
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (do_push) begin
            inst_mem[tail_q] <= push_inst_i;
            pc_mem[tail_q]   <= push_pc_i;
            br_mem[tail_q]   <= push_is_branch_i;
            tgt_mem[tail_q]  <= push_target_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push_i) begin
                tail_q <= tail_q + ptr_t'(1);
            end
            head_q  <= head_q + ptr_t'(issue_cnt_i);
            count_q <= count_q + count_t'(push_i) - count_t'(issue_cnt_i);
        end
    end

    assign count_o          = count_q;
    assign buf_full_o       = (count_q == count_t'(`FE_BUF_DEPTH));
    assign head_is_branch_o = br_mem[head_q];

    ////////////////////////////////////////////////////////////////////////////
    // Issue slot registers
    ////////////////////////////////////////////////////////////////////////////

    // Issue count is already zero under flush, stall and empty
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            slot0_valid_o     <= 1'b0;
            slot0_inst_o      <= '0;
            slot0_pc_o        <= '0;
            slot0_is_branch_o <= 1'b0;
            slot0_target_o    <= '0;
            slot1_valid_o     <= 1'b0;
            slot1_inst_o      <= '0;
            slot1_pc_o        <= '0;
            slot1_is_branch_o <= 1'b0;
            slot1_target_o    <= '0;
        end else if (!hold_slots) begin
            slot0_valid_o     <= take0;
            slot0_inst_o      <= take0 ? inst_mem[head_q] : '0;
            slot0_pc_o        <= take0 ? pc_mem[head_q] : '0;
            slot0_is_branch_o <= take0 && br_mem[head_q];
            slot0_target_o    <= take0 ? tgt_mem[head_q] : '0;
            slot1_valid_o     <= take1;
            slot1_inst_o      <= take1 ? inst_mem[head_p1] : '0;
            slot1_pc_o        <= take1 ? pc_mem[head_p1] : '0;
            slot1_is_branch_o <= take1 && br_mem[head_p1];
            slot1_target_o    <= take1 ? tgt_mem[head_p1] : '0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Protocol checks
    ////////////////////////////////////////////////////////////////////////////

    // Fetch must respect full
    a_no_push_full : assert property (@(posedge clk) disable iff (!rst_n_i)
        push_i |-> !buf_full_o)
        else $error("inst_buffer: push while full");

    // Never pop more than the buffer holds
    a_issue_le_count : assert property (@(posedge clk) disable iff (!rst_n_i)
        count_t'(issue_cnt_i) <= count_q)
        else $error("inst_buffer: issue count %0d exceeds occupancy %0d",
                    issue_cnt_i, count_q);

    // Group ends at a branch
    a_branch_ends_group : assert property (@(posedge clk) disable iff (!rst_n_i)
        slot1_valid_o |-> !slot0_is_branch_o)
        else $error("inst_buffer: slot1 issued behind a branch");

endmodule

// File: frontend_top.sv
module frontend_top (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                fetch_valid_i,
    input  fe_types_pkg::inst_t fetch_inst_i,
    input  fe_types_pkg::addr_t fetch_pc_i,
    input  logic                flush_i,
    input  logic                pause_i,
    input  logic                stall_i,
    output logic                slot0_valid_o,
    output fe_types_pkg::inst_t slot0_inst_o,
    output fe_types_pkg::addr_t slot0_pc_o,
    output logic                slot0_is_branch_o,
    output fe_types_pkg::addr_t slot0_target_o,
    output logic                slot1_valid_o,
    output fe_types_pkg::inst_t slot1_inst_o,
    output fe_types_pkg::addr_t slot1_pc_o,
    output logic                slot1_is_branch_o,
    output fe_types_pkg::addr_t slot1_target_o,
    output logic                buf_full_o
);

    import fe_types_pkg::*;
    import fe_ctrl_pkg::*;

    // Predecode to buffer write side
    logic       pd_is_branch;
    addr_t      pd_target;

    // Buffer and issue selector loop
    count_t     buf_count;
    logic       head_is_branch;
    issue_cnt_t issue_cnt;

    branch_predecode branch_predecode_i (
        .pc_i        (fetch_pc_i),
        .inst_i      (fetch_inst_i),
        .is_branch_o (pd_is_branch),
        .target_o    (pd_target)
    );

    issue_select issue_select_i (
        .count_i          (buf_count),
        .head_is_branch_i (head_is_branch),
        .flush_i          (flush_i),
        .pause_i          (pause_i),
        .stall_i          (stall_i),
        .issue_cnt_o      (issue_cnt)
    );

    inst_buffer inst_buffer_i (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .flush_i           (flush_i),
        .pause_i           (pause_i),
        .push_i            (fetch_valid_i),
        .push_inst_i       (fetch_inst_i),
        .push_pc_i         (fetch_pc_i),
        .push_is_branch_i  (pd_is_branch),
        .push_target_i     (pd_target),
        .issue_cnt_i       (issue_cnt),
        .count_o           (buf_count),
        .head_is_branch_o  (head_is_branch),
        .buf_full_o        (buf_full_o),
        .slot0_valid_o     (slot0_valid_o),
        .slot0_inst_o      (slot0_inst_o),
        .slot0_pc_o        (slot0_pc_o),
        .slot0_is_branch_o (slot0_is_branch_o),
        .slot0_target_o    (slot0_target_o),
        .slot1_valid_o     (slot1_valid_o),
        .slot1_inst_o      (slot1_inst_o),
        .slot1_pc_o        (slot1_pc_o),
        .slot1_is_branch_o (slot1_is_branch_o),
        .slot1_target_o    (slot1_target_o)
    );

endmodule

// File: tb_frontend.sv
`include "frontend_defines.svh"

module tb_frontend;

    import fe_types_pkg::*;

    logic  clk;
    logic  rst_n_i;
    logic  fetch_valid_i;
    inst_t fetch_inst_i;
    addr_t fetch_pc_i;
    logic  flush_i;
    logic  pause_i;
    logic  stall_i;
    logic  slot0_valid_o, slot0_is_branch_o, slot1_valid_o, slot1_is_branch_o, buf_full_o;
    inst_t slot0_inst_o, slot1_inst_o;
    addr_t slot0_pc_o, slot0_target_o, slot1_pc_o, slot1_target_o;

    integer      seed = 88628;
    int          pause_left = 0;
    int          stall_left = 0;
    int          occ = 0;
    addr_t       next_pc;
    inst_t       mq_inst [$];
    addr_t       mq_pc [$];
    logic [31:0] prev_fields [10];
    string       field_names [10] = '{"slot0_valid", "slot0_inst", "slot0_pc", "slot0_is_branch",
        "slot0_target", "slot1_valid", "slot1_inst", "slot1_pc", "slot1_is_branch", "slot1_target"};

    frontend_top frontend_top_i (.*);

    initial begin : clock_gen
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        int v;
        v = $random(seed);
        v = v & 32'h7fff_ffff;
        return v % n;
    endfunction

    // Mix of B-type, JAL and other opcodes
    function automatic inst_t make_inst();
        inst_t raw;
        int    kind;
        raw  = $random(seed);
        kind = rand_below(3);
        if (kind == 0) raw[6:0] = 7'b1100011;
        else if (kind == 1) raw[6:0] = 7'b1101111;
        else if (raw[6:0] == 7'b1100011 || raw[6:0] == 7'b1101111) raw[6:0] = 7'b0010011;
        return raw;
    endfunction

    // Expected predecode as {is_branch, target}
    function automatic logic [32:0] pre_ref(input inst_t inst, input addr_t pc);
        logic [31:0] b_imm;
        logic [31:0] j_imm;
        b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        case (inst[6:0])
            7'b1100011: return {1'b1, pc + b_imm};
            7'b1101111: return {1'b1, pc + j_imm};
            default:    return {1'b0, pc + 32'd4};
        endcase
    endfunction

    function automatic logic [31:0] slot_field(input int idx);
        case (idx)
            0: return 32'(slot0_valid_o);
            1: return slot0_inst_o;
            2: return slot0_pc_o;
            3: return 32'(slot0_is_branch_o);
            4: return slot0_target_o;
            5: return 32'(slot1_valid_o);
            6: return slot1_inst_o;
            7: return slot1_pc_o;
            8: return 32'(slot1_is_branch_o);
            default: return slot1_target_o;
        endcase
    endfunction

    // Group size from the model queue, pushes of this edge not yet visible
    function automatic int expected_issue();
        logic [32:0] head_ref;
        if (flush_i || pause_i || stall_i || mq_inst.size() == 0) return 0;
        head_ref = pre_ref(mq_inst[0], mq_pc[0]);
        if (mq_inst.size() == 1 || head_ref[32]) return 1;
        return 2;
    endfunction

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s mismatch, got %h expected %h", $time, what, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "stopping on first mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out while waiting for %s", what);
        $display("*** FAILED ***");
        $fatal(1, "stopping on timeout");
    endtask

    // Slot s against model entry s, or an empty slot with zero fields
    task automatic check_slot(input int s, input bit want);
        logic [32:0] ref_val;
        int          base;
        base = s * 5;
        if (want) begin
            ref_val = pre_ref(mq_inst[s], mq_pc[s]);
            check_val(field_names[base], slot_field(base), 32'd1);
            check_val(field_names[base + 1], slot_field(base + 1), mq_inst[s]);
            check_val(field_names[base + 2], slot_field(base + 2), mq_pc[s]);
            check_val(field_names[base + 3], slot_field(base + 3), 32'(ref_val[32]));
            check_val(field_names[base + 4], slot_field(base + 4), ref_val[31:0]);
        end else begin
            for (int i = 0; i < 5; i++) begin
                check_val(field_names[base + i], slot_field(base + i), 32'd0);
            end
        end
    endtask

    task automatic push_one();
        fetch_valid_i = 1'b1;
        fetch_inst_i  = make_inst();
        fetch_pc_i    = next_pc;
        next_pc       = next_pc + 32'd4;
    endtask

    // Random control bursts, fetch held off while full
    task automatic random_cycle();
        @(negedge clk);
        if (pause_left == 0 && rand_below(16) == 0) pause_left = 1 + rand_below(4);
        if (stall_left == 0 && rand_below(14) == 0) stall_left = 1 + rand_below(6);
        pause_i = (pause_left > 0);
        stall_i = (stall_left > 0);
        if (pause_left > 0) pause_left--;
        if (stall_left > 0) stall_left--;
        flush_i = (rand_below(40) == 0);
        if (!buf_full_o && rand_below(10) < 7) push_one();
        else fetch_valid_i = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Comparing process, samples just after each rising edge
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin : compare_proc
        int n_exp;
        int issued;
        #1;
        if (rst_n_i) begin
            if (pause_i && !flush_i) begin
                // Outputs frozen, nothing consumed
                for (int i = 0; i < 10; i++) begin
                    check_val(field_names[i], slot_field(i), prev_fields[i]);
                end
                issued = 0;
            end else begin
                n_exp = expected_issue();
                check_slot(0, n_exp >= 1);
                check_slot(1, n_exp == 2);
                issued = int'(slot0_valid_o) + int'(slot1_valid_o);
                repeat (n_exp) begin
                    void'(mq_inst.pop_front());
                    void'(mq_pc.pop_front());
                end
            end
            check_val("slot1 behind branch", 32'(slot1_valid_o && slot0_is_branch_o), 32'd0);
            if (flush_i) begin
                mq_inst.delete();
                mq_pc.delete();
                occ = 0;
            end else begin
                occ = occ + int'(fetch_valid_i) - issued;
                if (fetch_valid_i) begin
                    mq_inst.push_back(fetch_inst_i);
                    mq_pc.push_back(fetch_pc_i);
                end
            end
            check_val("buf_full_o", 32'(buf_full_o), 32'(occ == `FE_BUF_DEPTH));
        end
        for (int i = 0; i < 10; i++) begin
            prev_fields[i] = slot_field(i);
        end
    end

    initial begin : main_proc
        int pushes;
        int waited;
        rst_n_i       = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_inst_i  = '0;
        fetch_pc_i    = '0;
        flush_i       = 1'b0;
        pause_i       = 1'b0;
        stall_i       = 1'b0;
        next_pc       = 32'h0000_1000;
        repeat (10) @(negedge clk);
        check_val("slot0_valid in reset", 32'(slot0_valid_o), 32'd0);
        check_val("slot1_valid in reset", 32'(slot1_valid_o), 32'd0);
        check_val("buf_full_o in reset", 32'(buf_full_o), 32'd0);
        rst_n_i = 1'b1;

        repeat (1500) random_cycle();

        // Fill under stall, then drain in order
        @(negedge clk);
        flush_i       = 1'b1;
        stall_i       = 1'b1;
        pause_i       = 1'b0;
        fetch_valid_i = 1'b0;
        pushes        = 0;
        waited        = 0;
        @(negedge clk);
        flush_i = 1'b0;
        while (!buf_full_o) begin
            if (waited > 40) timeout_fail("buf_full_o to rise under stall");
            push_one();
            pushes++;
            waited++;
            @(negedge clk);
        end
        fetch_valid_i = 1'b0;
        check_val("net pushes until full", pushes, `FE_BUF_DEPTH);
        stall_i = 1'b0;
        waited  = 0;
        while (mq_inst.size() != 0 || slot0_valid_o || slot1_valid_o) begin
            if (waited > 60) timeout_fail("the buffer to drain");
            waited++;
            @(negedge clk);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: frontend.f
+incdir+.
fe_types_pkg.sv
fe_ctrl_pkg.sv
branch_predecode.sv
issue_select.sv
inst_buffer.sv
frontend_top.sv
tb_frontend.sv

// File: run.sh
#!/bin/sh
# Build and run the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_frontend \
    -f frontend.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_frontend
if [ $? -ne 0 ]; then
    echo "Simulation failed"
    exit 1
fi

exit 0
